/* Makefile */
# Verilator build and run for the CR16 execution unit testbench

VERILATOR ?= verilator
TOP       ?= cr16ExecTb
FILELIST  ?= cr16Exec.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) cr16_defs.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, the header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* cr16Alu.sv */
`include "cr16_defs.svh"

module cr16Alu
(
	input  cr16AluPkg::aluOpE          op,
	input  logic [`CR16_DATA_W-1:0]    dst,
	input  logic [`CR16_DATA_W-1:0]    src,
	input  logic                       carryIn,
	output logic [`CR16_DATA_W-1:0]    result,
	output logic [`CR16_FLAGS_W-1:0]   flagsNew,
	output logic [`CR16_FLAGS_W-1:0]   flagMask
);

	// Sum with one extra bit so the carry falls out at the top
	logic [`CR16_DATA_W:0]   sumWide;
	// Difference used by the compare for its overflow flag
	logic [`CR16_DATA_W-1:0] diff;
	// Shift distance as a magnitude plus a direction
	logic [`CR16_DATA_W-1:0] shiftMag;
	logic                    shiftRight;
	// High when every bit gets shifted out
	logic                    shiftOut;
	// Fill pattern for an arithmetic right shift past the word
	logic [`CR16_DATA_W-1:0] signFill;

	always_comb
	begin
		sumWide    = {1'b0, dst} + {1'b0, src} + {{`CR16_DATA_W{1'b0}}, carryIn};
		diff       = dst - src;
		// A negative amount means a right shift by its two's complement magnitude
		shiftRight = src[`CR16_DATA_W-1];
		shiftMag   = shiftRight ? (~src + 1'b1) : src;
		// The most negative amount also lands here since its magnitude is huge
		shiftOut   = (shiftMag >= `CR16_DATA_W'(`CR16_DATA_W));
		signFill   = {`CR16_DATA_W{dst[`CR16_DATA_W-1]}};
	end

	always_comb
	begin
		// Defaults cover unknown opcodes with a zero result and no flag change
		result   = '0;
		flagsNew = '0;
		flagMask = '0;
		case (op)
			cr16AluPkg::opAdd:
			begin
				result                       = sumWide[`CR16_DATA_W-1:0];
				flagsNew[cr16AluPkg::flagC]  = sumWide[`CR16_DATA_W];
				flagMask[cr16AluPkg::flagC]  = 1'b1;
			end
			cr16AluPkg::opOr:
				result = dst | src;
			cr16AluPkg::opAnd:
				result = dst & src;
			cr16AluPkg::opXor:
				result = dst ^ src;
			cr16AluPkg::opMov:
				result = src;
			cr16AluPkg::opCmp:
			begin
				// The difference shows on the result port but is never written back
				result                       = diff;
				flagsNew[cr16AluPkg::flagL]  = (dst < src);
				flagsNew[cr16AluPkg::flagN]  = ($signed(dst) < $signed(src));
				flagsNew[cr16AluPkg::flagZ]  = (dst == src);
				// Overflow when the operand signs differ and the difference loses dst's sign
				flagsNew[cr16AluPkg::flagF]  = (dst[`CR16_DATA_W-1] != src[`CR16_DATA_W-1]) &&
					(diff[`CR16_DATA_W-1] != dst[`CR16_DATA_W-1]);
				flagMask[cr16AluPkg::flagL]  = 1'b1;
				flagMask[cr16AluPkg::flagN]  = 1'b1;
				flagMask[cr16AluPkg::flagZ]  = 1'b1;
				flagMask[cr16AluPkg::flagF]  = 1'b1;
			end
			cr16AluPkg::opLsh:
			begin
				// Logical shift fills with zeros both ways
				if (shiftOut)
					result = '0;
				else if (shiftRight)
					result = dst >> shiftMag;
				else
					result = dst << shiftMag;
			end
			cr16AluPkg::opAshu:
			begin
				// Left shifts match LSH, right shifts replicate the sign
				if (shiftRight)
				begin
					if (shiftOut)
						result = signFill;
					else
						result = $signed(dst) >>> shiftMag;
				end
				else
					result = shiftOut ? '0 : (dst << shiftMag);
			end
			default:
				result = '0;
		endcase
	end

endmodule

/* cr16AluPkg.sv */
`include "cr16_defs.svh"

package cr16AluPkg;

	// Opcode values follow the legacy ALU encoding
	// Anything outside this list is treated as an unknown opcode
	typedef enum logic [`CR16_OP_W-1:0]
	{
		opAnd  = 8'b00000001,
		opOr   = 8'b00000010,
		opXor  = 8'b00000011,
		opAdd  = 8'b00000101,
		opCmp  = 8'b00001011,
		opMov  = 8'b00001101,
		opLsh  = 8'b10000100,
		opAshu = 8'b10000110
	} aluOpE;

	// Carry out of ADD
	localparam int unsigned flagC = 0;

	// Low flag, set when dst is below src as unsigned numbers
	localparam int unsigned flagL = 1;

	// Signed overflow of the compare subtraction
	localparam int unsigned flagF = 2;

	// Set when both compare operands are equal
	localparam int unsigned flagZ = 3;

	// Set when dst is below src as signed numbers
	localparam int unsigned flagN = 4;

endpackage

/* cr16CmdPkg.sv */
`include "cr16_defs.svh"

package cr16CmdPkg;

	// Phases of one four-phase command handshake
	// Idle waits for req, exec does the work, done holds ack until req drops
	typedef enum logic [1:0]
	{
		ctlIdle = 2'd0,
		ctlExec = 2'd1,
		ctlDone = 2'd2
	} ctlStateE;

	// Tells whether an opcode stores its result in the destination register
	// CMP only touches the flags and unknown opcodes touch nothing
	function automatic logic writesBack(input logic [`CR16_OP_W-1:0] op);
		case (op)
			cr16AluPkg::opAdd, cr16AluPkg::opOr, cr16AluPkg::opAnd, cr16AluPkg::opXor,
			cr16AluPkg::opMov, cr16AluPkg::opLsh, cr16AluPkg::opAshu:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

endpackage

/* cr16Exec.f */
+incdir+.
cr16AluPkg.sv
cr16CmdPkg.sv
cr16Alu.sv
cr16RegFile.sv
cr16ExecCtl.sv
cr16Exec.sv
cr16Exec_props.sv
cr16ExecTb.sv

/* cr16Exec.sv */
`include "cr16_defs.svh"

module cr16Exec
(
	input  logic                        clk,
	input  logic                        arstN,
	input  logic                        req,
	input  logic [`CR16_OP_W-1:0]       op,
	input  logic [`CR16_REG_IDX_W-1:0]  rDest,
	input  logic [`CR16_REG_IDX_W-1:0]  rSrc,
	input  logic [`CR16_DATA_W-1:0]     imm,
	input  logic                        useImm,
	input  logic                        withCarry,
	output logic                        ack,
	output logic [`CR16_DATA_W-1:0]     result,
	output logic [`CR16_FLAGS_W-1:0]    flags
);

	// Register file read data
	logic [`CR16_DATA_W-1:0]  rdDst;
	logic [`CR16_DATA_W-1:0]  rdSrc;
	// Operand and carry chosen by the controller
	logic [`CR16_DATA_W-1:0]  aluSrc;
	logic                     aluCarryIn;
	// ALU outcome
	logic [`CR16_DATA_W-1:0]  aluResult;
	logic [`CR16_FLAGS_W-1:0] aluFlagsNew;
	logic [`CR16_FLAGS_W-1:0] aluFlagMask;
	logic                     wrEn;

	cr16ExecCtl ctl0 (.clk, .arstN, .req, .op, .useImm, .withCarry, .imm, .rdSrc,
		.aluResult, .aluFlagsNew, .aluFlagMask, .aluSrc, .aluCarryIn, .wrEn,
		.ack, .result, .flags);

	// The destination register is both read as an operand and written with the result
	cr16RegFile regFile0 (.clk, .arstN, .rdIdxA(rDest), .rdIdxB(rSrc),
		.rdDataA(rdDst), .rdDataB(rdSrc), .wrEn, .wrIdx(rDest), .wrData(aluResult));

	// Raw opcodes outside the enum still reach the ALU and hit its default branch
	cr16Alu alu0 (.op(cr16AluPkg::aluOpE'(op)), .dst(rdDst), .src(aluSrc),
		.carryIn(aluCarryIn), .result(aluResult), .flagsNew(aluFlagsNew),
		.flagMask(aluFlagMask));

endmodule

/* cr16ExecCtl.sv */
`include "cr16_defs.svh"

module cr16ExecCtl
(
	input  logic                       clk,
	input  logic                       arstN,
	// Command side of the four-phase handshake
	input  logic                       req,
	input  logic [`CR16_OP_W-1:0]      op,
	input  logic                       useImm,
	input  logic                       withCarry,
	input  logic [`CR16_DATA_W-1:0]    imm,
	// Source register value from the register file
	input  logic [`CR16_DATA_W-1:0]    rdSrc,
	// ALU outcome for the current command
	input  logic [`CR16_DATA_W-1:0]    aluResult,
	input  logic [`CR16_FLAGS_W-1:0]   aluFlagsNew,
	input  logic [`CR16_FLAGS_W-1:0]   aluFlagMask,
	// ALU operand controls
	output logic [`CR16_DATA_W-1:0]    aluSrc,
	output logic                       aluCarryIn,
	// Register file write strobe
	output logic                       wrEn,
	// Handshake reply and the values it vouches for
	output logic                       ack,
	output logic [`CR16_DATA_W-1:0]    result,
	output logic [`CR16_FLAGS_W-1:0]   flags
);

	cr16CmdPkg::ctlStateE state;

	// Immediate commands bypass the source register entirely
	assign aluSrc = useImm ? imm : rdSrc;

	// Carry only chains in when the command asks for it
	assign aluCarryIn = withCarry & flags[cr16AluPkg::flagC];

	// One write per command, on the edge that leaves exec
	// The opcode is still held by the driver at that point
	assign wrEn = (state == cr16CmdPkg::ctlExec) && cr16CmdPkg::writesBack(op);

	// Ack follows the done state directly so it drops on the edge that sees req low
	assign ack = (state == cr16CmdPkg::ctlDone);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state  <= cr16CmdPkg::ctlIdle;
			result <= '0;
			flags  <= '0;
		end
		else
		begin
			case (state)
				cr16CmdPkg::ctlIdle:
				begin
					// A new command is only taken once the previous ack has gone low
					if (req)
					begin
						state <= cr16CmdPkg::ctlExec;
					end
				end
				cr16CmdPkg::ctlExec:
				begin
					// Result and status are captured together with the register write
					result <= aluResult;
					// Only the flags the opcode defines are replaced
					flags  <= (flags & ~aluFlagMask) | (aluFlagsNew & aluFlagMask);
					state  <= cr16CmdPkg::ctlDone;
				end
				cr16CmdPkg::ctlDone:
				begin
					// Hold ack for as long as the driver keeps req up
					if (!req)
					begin
						state <= cr16CmdPkg::ctlIdle;
					end
				end
				default:
				begin
					state <= cr16CmdPkg::ctlIdle;
				end
			endcase
		end
	end

endmodule

/* cr16ExecTb.sv */
`include "cr16_defs.svh"

module cr16ExecTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numCmds = 400;
	// Worst handshake is about eight cycles with the longest hold, so ten leaves slack
	localparam int timeoutCycles = numCmds * 10 + 50;

	logic                         clk = 1'b0;
	logic                         arstN;
	logic                         req;
	logic [`CR16_OP_W-1:0]        op;
	logic [`CR16_REG_IDX_W-1:0]   rDest;
	logic [`CR16_REG_IDX_W-1:0]   rSrc;
	logic [`CR16_DATA_W-1:0]      imm;
	logic                         useImm;
	logic                         withCarry;
	logic                         ack;
	logic [`CR16_DATA_W-1:0]      result;
	logic [`CR16_FLAGS_W-1:0]     flags;

	// Reference copy of the architectural state
	logic [`CR16_DATA_W-1:0]  modelRegs [`CR16_NUM_REGS];
	logic [`CR16_FLAGS_W-1:0] modelFlags;

	logic [31:0] lcgState = 32'h1c9809e7;
	int          cmdCount = 0;
	int          ackRises = 0;
	logic        ackSeen = 1'b0;
	int          cycleCount = 0;

	cr16Exec dut0 (.clk, .arstN, .req, .op, .rDest, .rSrc, .imm, .useImm, .withCarry,
		.ack, .result, .flags);

	always #50 clk = ~clk;

	task automatic abortRun(input string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	// Hard stop in case a handshake never closes
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
			abortRun("timeout: handshake never completed");
	end

	// Every rising ack is one reply, so the total must equal the commands sent
	always @(negedge clk)
	begin
		if (ack && !ackSeen)
			ackRises <= ackRises + 1;
		ackSeen <= ack;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [`CR16_OP_W-1:0] opFromIndex(input logic [2:0] idx);
		case (idx)
			3'd0: return cr16AluPkg::opAdd;
			3'd1: return cr16AluPkg::opOr;
			3'd2: return cr16AluPkg::opAnd;
			3'd3: return cr16AluPkg::opXor;
			3'd4: return cr16AluPkg::opCmp;
			3'd5: return cr16AluPkg::opMov;
			3'd6: return cr16AluPkg::opLsh;
			default: return cr16AluPkg::opAshu;
		endcase
	endfunction

	function automatic logic isKnownOp(input logic [`CR16_OP_W-1:0] code);
		int i;
		for (i = 0; i < 8; i++)
			if (opFromIndex(3'(i)) == code)
				return 1'b1;
		return 1'b0;
	endfunction

	// Shifts one bit at a time, so sixteen or more steps empty the word naturally
	function automatic logic [15:0] shiftModel(input logic [15:0] value, input int amount,
		input logic arith);
		logic [15:0] v;
		int i;
		v = value;
		if (amount >= 0)
			for (i = 0; i < amount && i < 16; i++)
				v = {v[14:0], 1'b0};
		else
			for (i = 0; i < -amount && i < 16; i++)
				v = {arith ? v[15] : 1'b0, v[15:1]};
		return v;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else abortRun($sformatf("Mismatch at time %0t: %s expected %h, actual %h",
			$time, name, expected, actual));
	endtask

	// One full four-phase command, predicted from the model and checked at ack
	task automatic runCmd(input logic [7:0] cmdOp, input logic [3:0] cmdDest,
		input logic [3:0] cmdSrc, input logic [15:0] cmdImm, input logic cmdUseImm,
		input logic cmdWithCarry, input int holdExtra);
		logic [15:0] dstVal;
		logic [15:0] srcVal;
		logic [15:0] expResult;
		logic [4:0]  expFlags;
		logic        expWrite;
		int          sum;
		int          waitCycles;
		dstVal    = modelRegs[cmdDest];
		srcVal    = cmdUseImm ? cmdImm : modelRegs[cmdSrc];
		expResult = '0;
		expFlags  = modelFlags;
		expWrite  = 1'b0;
		case (cmdOp)
			cr16AluPkg::opAdd:
			begin
				sum = int'(dstVal) + int'(srcVal) +
					((cmdWithCarry && modelFlags[cr16AluPkg::flagC]) ? 1 : 0);
				expResult = sum[15:0];
				expFlags[cr16AluPkg::flagC] = (sum > 65535);
				expWrite = 1'b1;
			end
			cr16AluPkg::opCmp:
			begin
				// Exact signed difference, the compare still shows its low half as result
				sum = int'($signed(dstVal)) - int'($signed(srcVal));
				expResult = sum[15:0];
				expFlags[cr16AluPkg::flagL] = (int'(dstVal) < int'(srcVal));
				expFlags[cr16AluPkg::flagN] = (sum < 0);
				expFlags[cr16AluPkg::flagZ] = (sum == 0);
				expFlags[cr16AluPkg::flagF] = (sum > 32767) || (sum < -32768);
			end
			cr16AluPkg::opOr:
			begin
				expResult = dstVal | srcVal;
				expWrite = 1'b1;
			end
			cr16AluPkg::opAnd:
			begin
				expResult = dstVal & srcVal;
				expWrite = 1'b1;
			end
			cr16AluPkg::opXor:
			begin
				expResult = dstVal ^ srcVal;
				expWrite = 1'b1;
			end
			cr16AluPkg::opMov:
			begin
				expResult = srcVal;
				expWrite = 1'b1;
			end
			cr16AluPkg::opLsh, cr16AluPkg::opAshu:
			begin
				expResult = shiftModel(dstVal, int'($signed(srcVal)),
					cmdOp == cr16AluPkg::opAshu);
				expWrite = 1'b1;
			end
			default:
				expResult = '0;
		endcase
		@(posedge clk);
		req       <= 1'b1;
		op        <= cmdOp;
		rDest     <= cmdDest;
		rSrc      <= cmdSrc;
		imm       <= cmdImm;
		useImm    <= cmdUseImm;
		withCarry <= cmdWithCarry;
		waitCycles = 0;
		@(negedge clk);
		while (!ack)
		begin
			waitCycles++;
			@(negedge clk);
		end
		checkValue("ack latency", 16'd2, 16'(waitCycles));
		checkValue("result", expResult, result);
		checkValue("flags", 16'(expFlags), 16'(flags));
		// Back-pressure: ack and the reply must survive a lingering req
		repeat (holdExtra)
		begin
			@(negedge clk);
			checkValue("ack", 16'd1, 16'(ack));
			checkValue("result", expResult, result);
			checkValue("flags", 16'(expFlags), 16'(flags));
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		checkValue("result", expResult, result);
		while (ack)
			@(negedge clk);
		if (expWrite)
			modelRegs[cmdDest] = expResult;
		modelFlags = expFlags;
		cmdCount++;
	endtask

	task automatic randomCmd();
		logic [31:0] r;
		logic [31:0] f;
		logic [7:0]  cmdOp;
		logic [15:0] cmdImm;
		r = nextRand();
		// About one command in sixteen carries an opcode the unit does not know
		if (r[31:28] == 4'hf)
			cmdOp = isKnownOp(r[15:8]) ? 8'hff : r[15:8];
		else
			cmdOp = opFromIndex(r[27:25]);
		f = nextRand();
		r = nextRand();
		// Small signed amounts reach both directions and just past the word width
		if ((cmdOp == cr16AluPkg::opLsh || cmdOp == cr16AluPkg::opAshu) && r[15])
			cmdImm = 16'(int'(r[21:16]) - 32);
		else
			cmdImm = r[31:16];
		runCmd(cmdOp, f[31:28], f[27:24], cmdImm, f[23], f[22], int'(f[14:13]));
	endtask

	initial
	begin
		int i;
		arstN     <= 1'b0;
		req       <= 1'b0;
		op        <= '0;
		rDest     <= '0;
		rSrc      <= '0;
		imm       <= '0;
		useImm    <= 1'b0;
		withCarry <= 1'b0;
		for (i = 0; i < `CR16_NUM_REGS; i++)
			modelRegs[i] = '0;
		modelFlags = '0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkValue("ack", 16'd0, 16'(ack));
		checkValue("result", 16'd0, result);
		checkValue("flags", 16'd0, 16'(flags));
		runCmd(cr16AluPkg::opMov, 4'd1, 4'd5, 16'h0000, 1'b0, 1'b0, 0);
		// Give every register a random starting value
		for (i = 0; i < `CR16_NUM_REGS; i++)
			runCmd(cr16AluPkg::opMov, 4'(i), 4'd0, 16'(nextRand() >> 16), 1'b1, 1'b0, i % 4);
		// Equal compare, then a MOV shows the destination survived
		runCmd(cr16AluPkg::opMov, 4'd2, 4'd0, 16'h0005, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opMov, 4'd3, 4'd0, 16'h0005, 1'b1, 1'b0, 1);
		runCmd(cr16AluPkg::opCmp, 4'd2, 4'd3, 16'h0000, 1'b0, 1'b0, 0);
		runCmd(cr16AluPkg::opMov, 4'd7, 4'd2, 16'h0000, 1'b0, 1'b0, 2);
		// Most negative minus one overflows, small minus minus one is unsigned low
		runCmd(cr16AluPkg::opMov, 4'd4, 4'd0, 16'h8000, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opCmp, 4'd4, 4'd0, 16'h0001, 1'b1, 1'b0, 3);
		runCmd(cr16AluPkg::opCmp, 4'd2, 4'd0, 16'hffff, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opMov, 4'd6, 4'd0, 16'h7fff, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opCmp, 4'd6, 4'd0, 16'h8000, 1'b1, 1'b0, 1);
		// Carry out of a full word, then chained into the next add
		runCmd(cr16AluPkg::opMov, 4'd8, 4'd0, 16'hffff, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opAdd, 4'd8, 4'd0, 16'h0001, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opAdd, 4'd9, 4'd0, 16'h0003, 1'b1, 1'b1, 2);
		// Shifts past the word and a plain right shift
		runCmd(cr16AluPkg::opLsh, 4'd4, 4'd0, 16'h0010, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opMov, 4'd4, 4'd0, 16'h8000, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opAshu, 4'd4, 4'd0, 16'hfff0, 1'b1, 1'b0, 1);
		runCmd(cr16AluPkg::opMov, 4'd5, 4'd0, 16'hf00f, 1'b1, 1'b0, 0);
		runCmd(cr16AluPkg::opLsh, 4'd5, 4'd0, 16'hfffc, 1'b1, 1'b0, 0);
		runCmd(8'hff, 4'd5, 4'd6, 16'h1234, 1'b0, 1'b1, 2);
		while (cmdCount < numCmds)
			randomCmd();
		repeat (2) @(negedge clk);
		assert (ackRises == cmdCount)
		begin
			$display("NO ERRORS");
			$finish;
		end
		else
			abortRun($sformatf("Mismatch at time %0t: ack count expected %0d, actual %0d",
				$time, cmdCount, ackRises));
	end

endmodule

/* cr16Exec_props.sv */
`include "cr16_defs.svh"

module cr16Exec_props
(
	input logic                      clk,
	input logic                      arstN,
	input logic                      req,
	input logic                      ack,
	input logic [`CR16_DATA_W-1:0]   result,
	input logic [`CR16_FLAGS_W-1:0]  flags,
	input cr16CmdPkg::ctlStateE      state
);

	timeunit 1ns;
	timeprecision 1ps;

	// The unit never answers a command that was not asked for
	ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	// Back-pressure keeps ack up for as long as the driver holds req
	ackHeldByReq: assert property (@(posedge clk) disable iff (!arstN)
		(ack && req) |=> ack)
		else $error("ack dropped while req was still high");

	// The reply is frozen for the whole time ack is shown
	replyStable: assert property (@(posedge clk) disable iff (!arstN)
		ack |=> (!ack || ($stable(result) && $stable(flags))))
		else $error("result or flags moved while ack was high");

	// Leaving reset the controller sits idle with no reply pending
	quietAfterReset: assert property (@(posedge clk)
		$rose(arstN) |-> (!ack && state == cr16CmdPkg::ctlIdle))
		else $error("ack or controller state not idle right after reset");

endmodule

bind cr16ExecCtl cr16Exec_props props0 (.clk(clk), .arstN(arstN), .req(req), .ack(ack),
	.result(result), .flags(flags), .state(state));

/* cr16RegFile.sv */
`include "cr16_defs.svh"

module cr16RegFile
(
	input  logic                        clk,
	input  logic                        arstN,
	input  logic [`CR16_REG_IDX_W-1:0]  rdIdxA,
	input  logic [`CR16_REG_IDX_W-1:0]  rdIdxB,
	output logic [`CR16_DATA_W-1:0]     rdDataA,
	output logic [`CR16_DATA_W-1:0]     rdDataB,
	input  logic                        wrEn,
	input  logic [`CR16_REG_IDX_W-1:0]  wrIdx,
	input  logic [`CR16_DATA_W-1:0]     wrData
);

	// General purpose registers
	logic [`CR16_DATA_W-1:0] regs [`CR16_NUM_REGS];

	// Both read ports are plain lookups with no latency
	// A write in the same cycle only shows up after the edge
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

	// The architecture defines every register as zero out of reset
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `CR16_NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			regs[wrIdx] <= wrData;
		end
	end

endmodule

/* cr16_defs.svh */
`ifndef CR16_DEFS_SVH
`define CR16_DEFS_SVH

// Width of every data path in the unit
`define CR16_DATA_W 16

// Number of general purpose registers in the register file
`define CR16_NUM_REGS 16

// Bits needed to address one register
`define CR16_REG_IDX_W 4

// Opcode field width as seen on the command port
`define CR16_OP_W 8

// Width of the processor status vector (C, L, F, Z and N)
`define CR16_FLAGS_W 5

`endif
